//--- source/hk_pkg.sv
/*
 * Shared widths, codes and types of the board housekeeping block.
 * Counter widths are cut down for short simulations. The board uses
 * 17 bits for the settle counter and 28 bits for the blink counter.
 */
package hk_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Identification codes
  localparam logic [7:0] DEVICE_ID       = 8'h2f;
  localparam logic [7:0] DEVICE_REVISION = 8'd4;  // Both straps low

  localparam logic [7:0] REV_ID_STRAP_11 = 8'd1;
  localparam logic [7:0] REV_ID_STRAP_10 = 8'd2;
  localparam logic [7:0] REV_ID_STRAP_01 = 8'd3;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  localparam int BOARD_REV_W  = 2;
  localparam int SETTLE_CNT_W = 12;  // Ready after 15/16 of full range
  localparam int LED_CNT_W    = 14;
  localparam int SYNC_STAGES  = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Status levels from the PCIe core, start-up FSM and application

  typedef struct packed {
    logic startup_mode_pcie;  // 1 for the PCIe start path, 0 for USB
    logic user_reset;
    logic link_up;
    logic usb2_fsm_done;
    logic led_aux;            // Application LED
  } status_levels_t;

  // Idle levels while in reset. PCIe mode keeps the USB oscillator off
  localparam status_levels_t STATUS_IDLE = '{
    startup_mode_pcie: 1'b1,
    default:           1'b0
  };

  // Hardware configuration word as software reads it
  typedef struct packed {
    logic       present;   // Always set
    logic       usb_mode;
    logic [5:0] reserved;
    logic [7:0] dev_id;
    logic [7:0] rev_id;
    logic [7:0] low;
  } hwcfg_fields_t;

  typedef union packed {
    logic [31:0]   raw;
    hwcfg_fields_t fields;
  } hwcfg_word_t;

endpackage

//--- source/board_status_sync.sv
/*
 * Input synchroniser for status levels and board revision straps.
 * Both status_o and rev_id_o lag their pins by SYNC_STAGES cycles.
 * The revision decode register is the last strap stage.
 * SYNC_STAGES must be 2 or more.
 */
`timescale 1ns/1ps

module board_status_sync import hk_pkg::*; (
  input  logic                   cfg_mclk,
  input  logic                   reset_i,
  input  logic [BOARD_REV_W-1:0] board_rev_i,
  input  status_levels_t         status_i,
  output status_levels_t         status_o,
  output logic [7:0]             rev_id_o
);

  status_levels_t [SYNC_STAGES-1:0]      status_q;
  logic [SYNC_STAGES-2:0][BOARD_REV_W-1:0] strap_q;  // One stage short of status

  logic [BOARD_REV_W-1:0] strap_s;
  logic [7:0]             rev_id_d;
  logic [7:0]             rev_id_q;

  ////////////////////////////////////////////////////////////////////////////
  // Synchroniser chains

  always_ff @(posedge cfg_mclk) begin
    if (reset_i) begin
      status_q <= {SYNC_STAGES{STATUS_IDLE}};
      strap_q  <= '0;
    end else begin
      status_q[0] <= status_i;
      strap_q[0]  <= board_rev_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        status_q[i] <= status_q[i-1];
      end
      for (int i = 1; i < SYNC_STAGES - 1; i++) begin
        strap_q[i] <= strap_q[i-1];
      end
    end
  end

  assign strap_s  = strap_q[SYNC_STAGES-2];
  assign status_o = status_q[SYNC_STAGES-1];

  ////////////////////////////////////////////////////////////////////////////
  // Revision decode

  always_comb begin
    case (strap_s)
      2'b11:   rev_id_d = REV_ID_STRAP_11;
      2'b10:   rev_id_d = REV_ID_STRAP_10;
      2'b01:   rev_id_d = REV_ID_STRAP_01;
      default: rev_id_d = DEVICE_REVISION;  // Straps not fitted
    endcase
  end

  always_ff @(posedge cfg_mclk) begin
    if (reset_i) begin
      rev_id_q <= DEVICE_REVISION;  // Decode of cleared straps
    end else begin
      rev_id_q <= rev_id_d;
    end
  end

  assign rev_id_o = rev_id_q;

  // Software treats a zero revision as a missing board
  a_rev_id_nonzero: assert property (@(posedge cfg_mclk) disable iff (reset_i)
    rev_id_o != 8'h00)
    else $error("revision id reads zero");

endmodule

//--- source/osc_settle_timer.sv
/*
 * Oscillator settle timer for the USB start path.
 * Ready rises 15 * 2^(SETTLE_CNT_W-4) + 1 cycles after usb_mode_i rises
 * and holds until usb_mode_i drops. The counter wraps after ready.
 */
`timescale 1ns/1ps

module osc_settle_timer import hk_pkg::*; (
  input  logic cfg_mclk,
  input  logic reset_i,
  input  logic usb_mode_i,
  output logic usb_clk_ready_o
);

  logic [SETTLE_CNT_W-1:0] settle_cnt;
  logic                    top_nibble_full;
  logic                    ready_q;

  // Top 4 bits saturated means 15/16 of the range has elapsed
  assign top_nibble_full = &settle_cnt[SETTLE_CNT_W-1 -: 4];

  ////////////////////////////////////////////////////////////////////////////
  // Settle counter

  always_ff @(posedge cfg_mclk) begin
    if (reset_i) begin
      settle_cnt <= '0;
      ready_q    <= 1'b0;
    end else if (!usb_mode_i) begin
      // PCIe path holds the timer idle
      settle_cnt <= '0;
      ready_q    <= 1'b0;
    end else begin
      settle_cnt <= settle_cnt + 1'b1;
      if (top_nibble_full) begin
        ready_q <= 1'b1;  // Sticky until mode change
      end
    end
  end

  assign usb_clk_ready_o = ready_q;

  // USB PHY logic must not see the clock flag drop while the mode holds
  a_ready_held: assert property (@(posedge cfg_mclk) disable iff (reset_i)
    ($past(usb_mode_i) && $past(usb_clk_ready_o)) |-> usb_clk_ready_o)
    else $error("USB clock ready dropped while USB mode held");

endmodule

//--- source/led_status_blinker.sv
/*
 * Status LED pattern generator.
 * The blink counter runs freely and reads zero on the first cycle out of
 * reset. The LED output is active low and combinational from the counter
 * and the synchronised status levels.
 */
`timescale 1ns/1ps

module led_status_blinker import hk_pkg::*; (
  input  logic           cfg_mclk,
  input  logic           reset_i,
  input  status_levels_t status_i,
  output logic           gpledint_o
);

  logic [LED_CNT_W-1:0] blink_cnt;

  logic t2;
  logic t1;
  logic t0;

  logic pat_reset;
  logic pat_enum;
  logic pat_usb_init;

  logic led_pcie;
  logic led_usb;
  logic led_on;

  ////////////////////////////////////////////////////////////////////////////
  // Free-running blink counter

  always_ff @(posedge cfg_mclk) begin
    if (reset_i) begin
      blink_cnt <= '1;  // Wraps to zero on the first count
    end else begin
      blink_cnt <= blink_cnt + 1'b1;
    end
  end

  assign t2 = blink_cnt[LED_CNT_W-1];
  assign t1 = blink_cnt[LED_CNT_W-2];
  assign t0 = blink_cnt[LED_CNT_W-3];

  ////////////////////////////////////////////////////////////////////////////
  // Patterns over one period of the top three bits

  assign pat_reset    = t2 & t1 & t0;  // Short flash
  assign pat_enum     = t2 | t1;       // On-on-on-off
  assign pat_usb_init = t2 | t1 | t0;  // Long on, short off

  // PCIe path. Core reset wins over link state
  always_comb begin
    if (status_i.user_reset) begin
      led_pcie = pat_reset;
    end else if (!status_i.link_up) begin
      led_pcie = pat_enum;
    end else begin
      led_pcie = status_i.led_aux;
    end
  end

  // USB path blinks until the start-up FSM completes
  assign led_usb = status_i.usb2_fsm_done ? status_i.led_aux : pat_usb_init;

  assign led_on     = status_i.startup_mode_pcie ? led_pcie : led_usb;
  assign gpledint_o = ~led_on;  // LED pin sinks current

  // Status arrives from the synchroniser and must be resolved by then
  a_led_known: assert property (@(posedge cfg_mclk) disable iff (reset_i)
    !$isunknown(gpledint_o))
    else $error("LED output unknown");

endmodule

//--- source/hwcfg_word_builder.sv
/*
 * Hardware configuration word and oscillator buffer enable.
 * The word is registered one cycle after its inputs and reads zero in
 * reset. The buffer enable is combinational from the request and mode.
 */
`timescale 1ns/1ps

module hwcfg_word_builder import hk_pkg::*; (
  input  logic           cfg_mclk,
  input  logic           reset_i,
  input  status_levels_t status_i,
  input  logic [7:0]     rev_id_i,
  input  logic           osc_req_i,
  output hwcfg_word_t    hwcfg_o,
  output logic           osc_buf_en_o
);

  hwcfg_word_t word_d;
  logic        usb_mode;

  assign usb_mode = ~status_i.startup_mode_pcie;

  ////////////////////////////////////////////////////////////////////////////
  // Word assembly

  always_comb begin
    word_d.raw             = '0;  // Reserved and low byte stay zero
    word_d.fields.present  = 1'b1;
    word_d.fields.usb_mode = usb_mode;
    word_d.fields.dev_id   = DEVICE_ID;
    word_d.fields.rev_id   = rev_id_i;
  end

  always_ff @(posedge cfg_mclk) begin
    if (reset_i) begin
      hwcfg_o <= '0;
    end else begin
      hwcfg_o <= word_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Oscillator buffer

  // The USB PHY runs from the 26 MHz oscillator, so USB mode forces it on
  assign osc_buf_en_o = osc_req_i | usb_mode;

endmodule

//--- source/board_housekeeping_top.sv
/*
 * Board housekeeping top level, all in the cfg_mclk domain.
 * Status levels and straps are asynchronous to cfg_mclk and are
 * synchronised here. Reset is synchronous and active high.
 */
`timescale 1ns/1ps

module board_housekeeping_top import hk_pkg::*; (
  input  logic                   cfg_mclk,
  input  logic                   reset_i,

  input  logic [BOARD_REV_W-1:0] board_rev_i,
  input  status_levels_t         status_i,
  input  logic                   osc_req_i,   // Application oscillator request

  output hwcfg_word_t            hwcfg_o,
  output logic                   usb_clk_ready_o,
  output logic                   osc_buf_en_o,
  output logic                   gpledint_o   // Active low
);

  status_levels_t status_s;
  logic [7:0]     rev_id_s;
  logic           usb_mode_s;

  ////////////////////////////////////////////////////////////////////////////
  // Input side

  board_status_sync u_status_sync (
    .cfg_mclk    (cfg_mclk),
    .reset_i     (reset_i),
    .board_rev_i (board_rev_i),
    .status_i    (status_i),
    .status_o    (status_s),
    .rev_id_o    (rev_id_s)
  );

  assign usb_mode_s = ~status_s.startup_mode_pcie;

  ////////////////////////////////////////////////////////////////////////////
  // Processing

  osc_settle_timer u_settle_timer (
    .cfg_mclk        (cfg_mclk),
    .reset_i         (reset_i),
    .usb_mode_i      (usb_mode_s),
    .usb_clk_ready_o (usb_clk_ready_o)
  );

  led_status_blinker u_led_blinker (
    .cfg_mclk   (cfg_mclk),
    .reset_i    (reset_i),
    .status_i   (status_s),
    .gpledint_o (gpledint_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output side

  hwcfg_word_builder u_hwcfg (
    .cfg_mclk     (cfg_mclk),
    .reset_i      (reset_i),
    .status_i     (status_s),
    .rev_id_i     (rev_id_s),
    .osc_req_i    (osc_req_i),
    .hwcfg_o      (hwcfg_o),
    .osc_buf_en_o (osc_buf_en_o)
  );

endmodule

//--- bench/hk_ref.svh
/*
 * Reference models for the housekeeping testbench, built from the
 * revision table, the configuration word layout and the LED rules.
 * Included inside hk_tb after the hk_pkg import.
 */
`ifndef HK_REF_SVH
`define HK_REF_SVH

// Revision code from the board straps
function automatic logic [7:0] rev_ref(input logic [BOARD_REV_W-1:0] strap);
  logic [7:0] code;
  case (strap)
    2'b11:   code = REV_ID_STRAP_11;
    2'b10:   code = REV_ID_STRAP_10;
    2'b01:   code = REV_ID_STRAP_01;
    default: code = DEVICE_REVISION;  // No strap fitted
  endcase
  return code;
endfunction

// Word built bit by bit through the raw view
function automatic hwcfg_word_t word_ref(input logic [BOARD_REV_W-1:0] strap,
                                         input logic usb_mode);
  hwcfg_word_t w;
  w.raw = {1'b1, usb_mode, 6'b000000, DEVICE_ID, rev_ref(strap), 8'h00};
  return w;
endfunction

// LED level with the LED lit as 1, before the pin inversion
function automatic logic led_ref(input logic [LED_CNT_W-1:0] cnt,
                                 input status_levels_t st);
  logic t2;
  logic t1;
  logic t0;
  logic led_on;
  t2 = cnt[LED_CNT_W-1];
  t1 = cnt[LED_CNT_W-2];
  t0 = cnt[LED_CNT_W-3];
  if (st.startup_mode_pcie) begin
    if (st.user_reset) led_on = t2 & t1 & t0;
    else if (!st.link_up) led_on = t2 | t1;
    else led_on = st.led_aux;
  end else begin
    if (!st.usb2_fsm_done) led_on = t2 | t1 | t0;
    else led_on = st.led_aux;
  end
  return led_on;
endfunction

`endif

//--- bench/hk_tb.sv
/*
 * Testbench for board_housekeeping_top. Inputs change on the falling edge
 * and outputs are sampled there. Expected values come from hk_ref.svh and
 * a delay line that stands for the SYNC_STAGES input latency.
 */
`timescale 1ns/1ps

module hk_tb import hk_pkg::*; ();

  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 8;
  localparam int SETTLE_READY = 15 * 2**(SETTLE_CNT_W-4);  // Counts to ready
  localparam int LED_PERIOD   = 2**LED_CNT_W;
  // Five LED holds, settle waits and short tests, with margin
  localparam int TIMEOUT_CYCLES = 3 * SETTLE_READY + 6 * LED_PERIOD + 1000;

  logic                   cfg_mclk;
  logic                   reset_i;
  logic [BOARD_REV_W-1:0] board_rev_i;
  status_levels_t         status_i;
  logic                   osc_req_i;
  hwcfg_word_t            hwcfg_o;
  logic                   usb_clk_ready_o;
  logic                   osc_buf_en_o;
  logic                   gpledint_o;

  status_levels_t       sync_pipe [SYNC_STAGES];  // Levels as the DUT sees them
  logic [LED_CNT_W-1:0] led_cyc;                  // Cycles since reset release
  logic                 led_check_en;
  string                led_name;

  int seed;
  int cyc_total;
  int err_count;
  int test_errs;
  int tests_run;
  int tests_failed;

  `include "hk_ref.svh"

  board_housekeeping_top DUT (
    .cfg_mclk        (cfg_mclk),
    .reset_i         (reset_i),
    .board_rev_i     (board_rev_i),
    .status_i        (status_i),
    .osc_req_i       (osc_req_i),
    .hwcfg_o         (hwcfg_o),
    .usb_clk_ready_o (usb_clk_ready_o),
    .osc_buf_en_o    (osc_buf_en_o),
    .gpledint_o      (gpledint_o)
  );

  initial begin
    cfg_mclk = 1'b0;
    forever begin
      #CLK_HALF cfg_mclk = ~cfg_mclk;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bench models and timeout

  always @(posedge cfg_mclk) begin
    if (reset_i) begin
      led_cyc <= '1;
      for (int i = 0; i < SYNC_STAGES; i++) sync_pipe[i] <= STATUS_IDLE;
    end else begin
      led_cyc      <= led_cyc + 1'b1;
      sync_pipe[0] <= status_i;
      for (int i = 1; i < SYNC_STAGES; i++) sync_pipe[i] <= sync_pipe[i-1];
    end
  end

  always @(posedge cfg_mclk) begin
    cyc_total++;
    if (cyc_total >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_word(input string name, input hwcfg_word_t exp,
                            input hwcfg_word_t act);
    if (act !== exp) begin
      err_count++;
      test_errs++;
      $display("FAILED %s expected %08h actual %08h", name, exp.raw, act.raw);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_count++;
      test_errs++;
      $display("FAILED %s expected %b actual %b at %0t", name, exp, act, $time);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %-28s ok", name);
    end else begin
      tests_failed++;
      $display("test %-28s %0d mismatches", name, test_errs);
    end
    test_errs = 0;
  endtask

  // LED compare runs every cycle while a pattern case is held
  always @(negedge cfg_mclk) begin
    if (led_check_en) begin
      check_bit(led_name, ~led_ref(led_cyc, sync_pipe[SYNC_STAGES-1]), gpledint_o);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tests

  task automatic check_reset_values(input string name);
    test_errs = 0;
    osc_req_i = 1'b0;
    #1;
    check_word({name, " word"}, '0, hwcfg_o);
    check_bit({name, " ready"}, 1'b0, usb_clk_ready_o);
    check_bit({name, " osc_en low"}, 1'b0, osc_buf_en_o);  // USB pins ignored
    osc_req_i = 1'b1;
    #1;
    check_bit({name, " osc_en high"}, 1'b1, osc_buf_en_o);
    osc_req_i = 1'b0;
    finish_test(name);
  endtask

  task automatic run_rev_word();
    string name;
    logic [BOARD_REV_W-1:0] strap;
    for (int m = 0; m < 2; m++) begin
      for (int s = 0; s < 4; s++) begin
        strap = s[BOARD_REV_W-1:0];
        name  = $sformatf("rev_word strap=%b usb=%0d", strap, m);
        @(negedge cfg_mclk);
        board_rev_i = strap;
        status_i.startup_mode_pcie = (m == 0);
        repeat (SYNC_STAGES + 3) @(negedge cfg_mclk);
        check_word(name, word_ref(strap, m == 1), hwcfg_o);
        finish_test(name);
      end
    end
  endtask

  task automatic run_osc_enable();
    for (int req = 0; req < 2; req++) begin
      for (int usb = 0; usb < 2; usb++) begin
        @(negedge cfg_mclk);
        osc_req_i = (req == 1);
        status_i.startup_mode_pcie = (usb == 0);
        repeat (SYNC_STAGES + 1) @(negedge cfg_mclk);
        check_bit($sformatf("osc_en req=%0d usb=%0d", req, usb),
                  (req == 1) || (usb == 1), osc_buf_en_o);
      end
    end
    osc_req_i = 1'b0;
    finish_test("osc_enable");
  endtask

  task automatic run_settle();
    @(negedge cfg_mclk);
    status_i.startup_mode_pcie = 1'b1;
    repeat (SYNC_STAGES + 2) @(negedge cfg_mclk);
    check_bit("settle idle", 1'b0, usb_clk_ready_o);
    status_i.startup_mode_pcie = 1'b0;  // Start of the settle period
    repeat (SYNC_STAGES + SETTLE_READY) @(negedge cfg_mclk);
    check_bit("settle early", 1'b0, usb_clk_ready_o);
    repeat (2) @(negedge cfg_mclk);
    check_bit("settle ready", 1'b1, usb_clk_ready_o);
    status_i.startup_mode_pcie = 1'b1;
    repeat (SYNC_STAGES + 2) @(negedge cfg_mclk);
    check_bit("settle clear", 1'b0, usb_clk_ready_o);
    finish_test("settle_timing");
  endtask

  task automatic run_led_case(input string name, input status_levels_t st,
                              input logic rand_aux);
    int r;
    @(negedge cfg_mclk);
    status_i = st;
    repeat (SYNC_STAGES + 1) @(negedge cfg_mclk);
    test_errs    = 0;
    led_name     = name;
    led_check_en = 1'b1;
    repeat (LED_PERIOD + 8) begin
      @(negedge cfg_mclk);
      if (rand_aux) begin
        r = $random(seed);
        status_i.led_aux = r[0];
      end
    end
    led_check_en = 1'b0;
    finish_test(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence

  initial begin
    status_levels_t st;
    seed         = 87;
    cyc_total    = 0;
    err_count    = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    led_check_en = 1'b0;
    led_name     = "";
    reset_i      = 1'b1;
    board_rev_i  = '0;
    osc_req_i    = 1'b0;
    status_i     = STATUS_IDLE;
    status_i.startup_mode_pcie = 1'b0;  // USB pins must not leak in reset

    repeat (RESET_CYCLES) @(negedge cfg_mclk);
    check_reset_values("reset_at_start");
    reset_i = 1'b0;

    run_rev_word();
    run_osc_enable();
    run_settle();

    st = STATUS_IDLE;
    st.user_reset = 1'b1;
    run_led_case("led_pcie_user_reset", st, 1'b0);
    st.user_reset = 1'b0;
    run_led_case("led_pcie_no_link", st, 1'b0);
    st.link_up = 1'b1;
    run_led_case("led_pcie_linked", st, 1'b1);

    st = STATUS_IDLE;
    st.startup_mode_pcie = 1'b0;
    run_led_case("led_usb_init", st, 1'b0);
    st.usb2_fsm_done = 1'b1;
    run_led_case("led_usb_done", st, 1'b1);

    // Settled by now, so reset has a high ready flag to clear
    check_bit("ready before reset", 1'b1, usb_clk_ready_o);
    reset_i = 1'b1;
    repeat (RESET_CYCLES) @(negedge cfg_mclk);
    check_reset_values("reset_mid_run");
    reset_i = 1'b0;
    repeat (2) @(negedge cfg_mclk);

    $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- housekeeping.f
+incdir+bench
source/hk_pkg.sv
source/board_status_sync.sv
source/osc_settle_timer.sv
source/led_status_blinker.sv
source/hwcfg_word_builder.sv
source/board_housekeeping_top.sv
bench/hk_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the board housekeeping testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module hk_tb \
  -f housekeeping.f -o hk_sim > build.log 2>&1 \
  && ./obj_dir/hk_sim > sim.log 2>&1

# The testbench prints its verdict on a line of its own
grep -qx "Simulation passed" sim.log && echo "PASS" \
  || { echo "FAIL, see build.log and sim.log"; exit 1; }
